/* all.f */
+incdir+.
adc_types_pkg.sv
pn_seq_pkg.sv
pn_dev_predict.sv
pn_std_predict.sv
pn_check.sv
rx_pn_monitor.sv
rx_pn_top.sv
tb_pn_model.sv
tb_rx_pn_top.sv

/* tb_rx_pn_top.sv */
// Testbench for the I/Q pair PN monitor
// device and PN9 streams with injected errors and per-lane pn_err scoring
`include "pn_defines.svh"

module tb_rx_pn_top
  import tb_pn_model::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  logic        adc_clk;
  logic        reset;
  logic        adc_valid;
  logic [11:0] adc_data_i;
  logic [11:0] adc_data_q;
  logic [3:0]  pnseq_sel;
  logic        pn_oos_i;
  logic        pn_err_i;
  logic        pn_oos_q;
  logic        pn_err_q;

  // pattern state and mode (0 device pattern, 1 PN9 on I, 2 random on I)
  logic [15:0] dev_w;
  logic [8:0]  pn9_st;
  logic [31:0] lfsr_state;
  logic        q_primary;
  logic        use_gaps;
  int          mode;
  int          fails;
  int          timeouts;
  int          err_cnt_i;
  int          err_cnt_q;
  int          exp_i;
  int          exp_q;

  rx_pn_top #(
    .PRBS_POLY (pn_seq_pkg::PN9)
  ) DUT (
    .adc_clk    (adc_clk),
    .reset      (reset),
    .adc_valid  (adc_valid),
    .adc_data_i (adc_data_i),
    .adc_data_q (adc_data_q),
    .pnseq_sel  (pnseq_sel),
    .pn_oos_i   (pn_oos_i),
    .pn_err_i   (pn_err_i),
    .pn_oos_q   (pn_oos_q),
    .pn_err_q   (pn_err_q)
  );

  initial begin
    adc_clk = 1'b0;
    forever #20 adc_clk = ~adc_clk;
  end

  // scoreboard counts pn_err pulses per lane
  always @(negedge adc_clk) begin
    if (!reset && pn_err_i === 1'b1) err_cnt_i = err_cnt_i + 1;
    if (!reset && pn_err_q === 1'b1) err_cnt_q = err_cnt_q + 1;
  end

  task automatic take_bits(input int n, output logic [31:0] r);
    r = '0;
    repeat (n) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge adc_clk);
      adc_valid <= 1'b0;
    end
  endtask

  task automatic apply_reset(input logic [3:0] sel);
    @(posedge adc_clk);
    reset     <= 1'b1;
    adc_valid <= 1'b0;
    pnseq_sel <= sel;
    repeat (5) @(posedge adc_clk);
    reset <= 1'b0;
    @(negedge adc_clk);
  endtask

  // next sample of the active pattern with the flip masks applied on the wire
  task automatic send_next(input logic [11:0] flip_i, input logic [11:0] flip_q);
    logic [23:0] iq;
    logic [31:0] gap;
    logic [31:0] rnd;
    gap = '0;
    if (use_gaps) take_bits(2, gap);
    case (mode)
      0: begin
        iq    = dev_iq_pair(dev_w, q_primary);
        dev_w = dev_word_step(dev_w);
      end
      1: begin
        iq = {pn9_sample(pn9_st), 12'h000};
        repeat (12) pn9_st = pn9_step(pn9_st);
      end
      default: begin
        take_bits(12, rnd);
        iq = {rnd[11:0], 12'h000};
      end
    endcase
    idle(gap);
    @(posedge adc_clk);
    adc_valid  <= 1'b1;
    adc_data_i <= iq[23:12] ^ flip_i;
    adc_data_q <= iq[11:0] ^ flip_q;
    @(negedge adc_clk);
  endtask

  task automatic wait_lock(input logic lane_q, input int limit, input string what);
    int n;
    n = 0;
    while ((lane_q ? pn_oos_q : pn_oos_i) !== 1'b0 && n < limit) begin
      send_next(12'h000, 12'h000);
      n++;
    end
    if ((lane_q ? pn_oos_q : pn_oos_i) !== 1'b0) begin
      timeouts++;
      $display("Timeout: %s did not lock within %0d valid samples", what, limit);
    end
  endtask

  task automatic run_clean(input int n);
    repeat (n) send_next(12'h000, 12'h000);
  endtask

  // drain the pipeline before comparing pulse counts
  task automatic check_counts(input string what);
    idle(8);
    check_value(err_cnt_i, exp_i, {what, ", pn_err_i pulses"}, fails);
    check_value(err_cnt_q, exp_q, {what, ", pn_err_q pulses"}, fails);
    @(negedge adc_clk);
  endtask

  initial begin
    int n;
    reset = 1'b1;
    adc_valid = 1'b0;
    adc_data_i = '0;
    adc_data_q = '0;
    pnseq_sel = 4'h0;
    lfsr_state = 32'h58e7_d8b1;
    dev_w = 16'hace1;
    pn9_st = 9'h1ff;
    q_primary = 1'b0;
    use_gaps = 1'b0;
    mode = 0;
    {fails, timeouts, err_cnt_i, err_cnt_q, exp_i, exp_q} = '0;

    apply_reset(4'h0);
    check_value(pn_oos_i, 1, "pn_oos_i after reset", fails);
    check_value(pn_oos_q, 1, "pn_oos_q after reset", fails);
    check_value(pn_err_i, 0, "pn_err_i after reset", fails);
    check_value(pn_err_q, 0, "pn_err_q after reset", fails);

    // ************************************************
    // device pattern with I primary then Q primary
    // ************************************************
    wait_lock(1'b0, 40, "pn_oos_i on the device pattern");
    run_clean(20);
    check_counts("device lock on I");
    // bit 9 sits in the word but outside the I/Q overlap
    send_next(12'h200, 12'h000);
    exp_i++;
    run_clean(10);
    check_counts("single I error");
    check_value(pn_oos_i, 0, "pn_oos_i after single I error", fails);
    // Q bit 3 lands in the overlap byte
    send_next(12'h000, 12'h008);
    exp_i++;
    run_clean(10);
    check_counts("overlap mismatch");
    check_value(pn_oos_i, 0, "pn_oos_i after overlap mismatch", fails);

    q_primary = 1'b1;
    apply_reset(4'h0);
    wait_lock(1'b1, 40, "pn_oos_q on the device pattern");
    run_clean(20);
    check_counts("device lock on Q");
    send_next(12'h000, 12'h400);
    exp_q++;
    run_clean(10);
    check_counts("single Q error");
    check_value(pn_oos_q, 0, "pn_oos_q after single Q error", fails);

    // ************************************************
    // PN9 on I with random valid gaps
    // ************************************************
    mode = 1;
    use_gaps = 1'b1;
    apply_reset(`PN_SEL_STD);
    wait_lock(1'b0, 48, "pn_oos_i on PN9");
    run_clean(20);
    check_counts("PN9 lock");
    send_next(12'h020, 12'h000);
    exp_i++;
    run_clean(20);
    check_counts("single PN9 error");
    check_value(pn_oos_i, 0, "pn_oos_i after single PN9 error", fails);

    // random data on I must drop the lock within 20 words
    mode = 2;
    n = 0;
    while (pn_oos_i !== 1'b1 && n < 40) begin
      send_next(12'h000, 12'h000);
      n++;
    end
    if (pn_oos_i !== 1'b1) begin
      timeouts++;
      $display("Timeout: pn_oos_i did not rise within 40 samples of random data");
    end
    // each bad word in sync is reported, up to and including the one that drops the lock
    exp_i = exp_i + `PN_LOSS_COUNT;
    check_counts("loss of sync");

    $display("errors: %0d failed checks, %0d timeouts, pn_err pulses I %0d Q %0d",
             fails, timeouts, err_cnt_i, err_cnt_q);
    if (fails == 0 && timeouts == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* tb_pn_model.sv */
// PN monitor testbench model
// reference patterns, random bit source and the value check
package tb_pn_model;

  timeunit 1ns;
  timeprecision 100ps;

  // device word step, feedback from bits 15..4, 2 and 1
  function automatic logic [15:0] dev_word_step(input logic [15:0] w);
    logic fb;
    fb = w[2] ^ w[1];
    for (int k = 4; k < 16; k++) fb = fb ^ w[k];
    return {w[14:0], fb};
  endfunction

  // {i, q} for one device word
  // primary lane carries bits 15..4, the other lane bits 11..0 reversed
  function automatic logic [23:0] dev_iq_pair(input logic [15:0] w, input logic q_primary);
    logic [11:0] rev;
    for (int k = 0; k < 12; k++) rev[k] = w[11 - k];
    return q_primary ? {rev, w[15:4]} : {w[15:4], rev};
  endfunction

  // PN9 history with bit 0 oldest, s[n] = s[n-9] ^ s[n-5]
  function automatic logic [8:0] pn9_step(input logic [8:0] h);
    return {h[0] ^ h[4], h[8:1]};
  endfunction

  // next 12 stream bits, oldest in the msb
  function automatic logic [11:0] pn9_sample(input logic [8:0] h);
    logic [11:0] s;
    s = '0;
    for (int k = 0; k < 12; k++) begin
      h = pn9_step(h);
      s = {s[10:0], h[8]};
    end
    return s;
  endfunction

  // galois lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what, inout int fails);
    if (actual !== expected) begin
      fails++;
      $display("Fail at %0t ns: %s, got %0h expected %0h", $time, what, actual, expected);
    end
  endtask

endpackage

/* rx_pn_top.sv */
// PN monitors for one I/Q pair
// one monitor per lane, I primary and Q primary
module rx_pn_top
  import adc_types_pkg::*, pn_seq_pkg::*;
#(
  parameter prbs_poly_t PRBS_POLY = PN9
) (
  input  logic        adc_clk,
  input  logic        reset,
  input  logic        adc_valid,
  input  adc_sample_t adc_data_i,
  input  adc_sample_t adc_data_q,
  input  logic [3:0]  pnseq_sel,
  output logic        pn_oos_i,
  output logic        pn_err_i,
  output logic        pn_oos_q,
  output logic        pn_err_q
);

  rx_pn_monitor #(
    .SWAP_IQ   (0),
    .PRBS_POLY (PRBS_POLY)
  ) mon_i (
    .adc_clk    (adc_clk),
    .reset      (reset),
    .adc_valid  (adc_valid),
    .adc_data_i (adc_data_i),
    .adc_data_q (adc_data_q),
    .pnseq_sel  (pnseq_sel),
    .pn_oos     (pn_oos_i),
    .pn_err     (pn_err_i)
  );

  rx_pn_monitor #(
    .SWAP_IQ   (1),
    .PRBS_POLY (PRBS_POLY)
  ) mon_q (
    .adc_clk    (adc_clk),
    .reset      (reset),
    .adc_valid  (adc_valid),
    .adc_data_i (adc_data_i),
    .adc_data_q (adc_data_q),
    .pnseq_sel  (pnseq_sel),
    .pn_oos     (pn_oos_q),
    .pn_err     (pn_err_q)
  );

endmodule

/* rx_pn_monitor.sv */
// Receive PN monitor for one primary channel
// runs device and standard predictors into a shared checker
module rx_pn_monitor
  import adc_types_pkg::*, pn_seq_pkg::*;
#(
  parameter int         SWAP_IQ   = 0,
  parameter prbs_poly_t PRBS_POLY = PN9
) (
  input  logic        adc_clk,
  input  logic        reset,
  input  logic        adc_valid,
  input  adc_sample_t adc_data_i,
  input  adc_sample_t adc_data_q,
  input  logic [3:0]  pnseq_sel,
  output logic        pn_oos,
  output logic        pn_err
);

  adc_sample_t  data_pri;
  adc_sample_t  data_sec;
  logic         dev_valid;
  pn_dev_word_t dev_data;
  pn_dev_word_t dev_pn;
  logic         std_valid;
  pn_word_t     std_data;
  pn_word_t     std_pn;

  // Q is primary when swapped
  assign data_pri = (SWAP_IQ == 1) ? adc_data_q : adc_data_i;
  assign data_sec = (SWAP_IQ == 1) ? adc_data_i : adc_data_q;

  pn_dev_predict u_dev (
    .adc_clk   (adc_clk),
    .reset     (reset),
    .adc_valid (adc_valid),
    .pn_oos    (pn_oos),
    .data_pri  (data_pri),
    .data_sec  (data_sec),
    .dev_valid (dev_valid),
    .dev_data  (dev_data),
    .dev_pn    (dev_pn)
  );

  // standard pattern lives on the primary lane only
  pn_std_predict #(
    .PRBS_POLY (PRBS_POLY)
  ) u_std (
    .adc_clk   (adc_clk),
    .reset     (reset),
    .adc_valid (adc_valid),
    .pn_oos    (pn_oos),
    .data_pri  (data_pri),
    .std_valid (std_valid),
    .std_data  (std_data),
    .std_pn    (std_pn)
  );

  pn_check u_check (
    .adc_clk   (adc_clk),
    .reset     (reset),
    .dev_valid (dev_valid),
    .std_valid (std_valid),
    .pnseq_sel (pnseq_sel),
    .dev_data  (dev_data),
    .dev_pn    (dev_pn),
    .std_data  (std_data),
    .std_pn    (std_pn),
    .pn_oos    (pn_oos),
    .pn_err    (pn_err)
  );

endmodule

/* pn_check.sv */
// PN stream checker
// selects one prediction stream, tracks sync and flags mismatching words
`include "pn_defines.svh"

module pn_check
  import adc_types_pkg::*;
(
  input  logic         adc_clk,
  input  logic         reset,
  input  logic         dev_valid,
  input  logic         std_valid,
  input  logic [3:0]   pnseq_sel,
  input  pn_dev_word_t dev_data,
  input  pn_dev_word_t dev_pn,
  input  pn_word_t     std_data,
  input  pn_word_t     std_pn,
  output logic         pn_oos,
  output logic         pn_err
);

  localparam int CNT_MAX = (`PN_LOCK_COUNT > `PN_LOSS_COUNT) ?
                           `PN_LOCK_COUNT : `PN_LOSS_COUNT;
  localparam int CNT_W   = $clog2(CNT_MAX + 1);

  logic             sel_std;
  logic             cmp_valid;
  pn_word_t         cmp_data;
  pn_word_t         cmp_pn;
  logic             cmp_match;
  logic [CNT_W-1:0] run_cnt;

  // **************************************************
  // stream select
  // **************************************************

  assign sel_std = (pnseq_sel == `PN_SEL_STD);

  always_ff @(posedge adc_clk) begin
    if (reset) begin
      cmp_valid <= 1'b0;
    end else begin
      cmp_valid <= sel_std ? std_valid : dev_valid;
    end
  end

  // device words widened by repeating the low byte on top
  always_ff @(posedge adc_clk) begin
    if (sel_std) begin
      cmp_data <= std_data;
      cmp_pn   <= std_pn;
    end else begin
      cmp_data <= {dev_data[7:0], dev_data};
      cmp_pn   <= {dev_pn[7:0], dev_pn};
    end
  end

  // **************************************************
  // sync state, pn_oos is the state bit
  // **************************************************

  // all zero data is a dead link, never a match
  assign cmp_match = (cmp_data == cmp_pn) && (cmp_data != '0);

  // run_cnt counts matches while out of sync, mismatches while in sync
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      pn_oos  <= 1'b1;
      pn_err  <= 1'b0;
      run_cnt <= '0;
    end else begin
      pn_err <= 1'b0;
      if (cmp_valid) begin
        if (pn_oos) begin
          if (!cmp_match) begin
            run_cnt <= '0;
          end else if (run_cnt == CNT_W'(`PN_LOCK_COUNT - 1)) begin
            pn_oos  <= 1'b0;
            run_cnt <= '0;
          end else begin
            run_cnt <= run_cnt + CNT_W'(1);
          end
        end else begin
          if (cmp_match) begin
            run_cnt <= '0;
          end else begin
            // every bad word in sync is reported, including the last one
            pn_err <= 1'b1;
            if (run_cnt == CNT_W'(`PN_LOSS_COUNT - 1)) begin
              pn_oos  <= 1'b1;
              run_cnt <= '0;
            end else begin
              run_cnt <= run_cnt + CNT_W'(1);
            end
          end
        end
      end
    end
  end

endmodule

/* pn_std_predict.sv */
// Standard pattern predictor
// pairs primary samples into 24-bit words and predicts the next PN word
module pn_std_predict
  import adc_types_pkg::*, pn_seq_pkg::*;
#(
  parameter prbs_poly_t PRBS_POLY = PN9
) (
  input  logic        adc_clk,
  input  logic        reset,
  input  logic        adc_valid,
  input  logic        pn_oos,
  input  adc_sample_t data_pri,
  output logic        std_valid,
  output pn_word_t    std_data,
  output pn_word_t    std_pn
);

  logic        phase;
  adc_sample_t first_sample;
  logic        pair_done;
  logic        pair_valid;
  pn_word_t    pair_word;
  pn_word_t    pn_seed;

  // phase high means the upper half is held and this sample closes the pair
  assign pair_done = phase & adc_valid;

  // stage 1, pairing
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      phase      <= 1'b0;
      pair_valid <= 1'b0;
    end else begin
      pair_valid <= pair_done;
      if (adc_valid) begin
        phase <= ~phase;
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (adc_valid) begin
      first_sample <= data_pri;
    end
    if (pair_done) begin
      pair_word <= {first_sample, data_pri};
    end
  end

  // stage 2, register word and step prediction
  assign pn_seed = pn_oos ? std_data : std_pn;

  always_ff @(posedge adc_clk) begin
    if (reset) begin
      std_valid <= 1'b0;
    end else begin
      std_valid <= pair_valid;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (pair_valid) begin
      std_data <= pair_word;
      std_pn   <= pn_std_next(PRBS_POLY, pn_seed);
    end
  end

endmodule

/* pn_dev_predict.sv */
// Device pattern predictor
// builds 16-bit words from an I/Q pair and predicts the next device word
module pn_dev_predict
  import adc_types_pkg::*, pn_seq_pkg::*;
(
  input  logic         adc_clk,
  input  logic         reset,
  input  logic         adc_valid,
  input  logic         pn_oos,
  input  adc_sample_t  data_pri,
  input  adc_sample_t  data_sec,
  output logic         dev_valid,
  output pn_dev_word_t dev_data,
  output pn_dev_word_t dev_pn
);

  adc_sample_t  sec_rev;
  logic         iq_match;
  pn_dev_word_t word_s;
  logic         word_valid;
  pn_dev_word_t word;
  pn_dev_word_t pn_seed;

  // secondary lane arrives bit reversed
  always_comb begin
    for (int i = 0; i < $bits(adc_sample_t); i++) begin
      sec_rev[i] = data_sec[$bits(adc_sample_t)-1-i];
    end
  end

  // low nibble of the word is only carried on the secondary lane
  assign word_s   = {data_pri, sec_rev[3:0]};
  // both lanes carry the middle byte, so they must agree
  assign iq_match = (data_pri[7:0] == sec_rev[11:4]);

  // stage 1, word build
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      word_valid <= 1'b0;
    end else begin
      word_valid <= adc_valid;
    end
  end

  // a broken overlap gets a marker word that can never match
  always_ff @(posedge adc_clk) begin
    word <= iq_match ? word_s : 16'hdead;
  end

  // stage 2, register word and step prediction
  // out of sync the prediction restarts from the last received word
  assign pn_seed = pn_oos ? dev_data : dev_pn;

  always_ff @(posedge adc_clk) begin
    if (reset) begin
      dev_valid <= 1'b0;
    end else begin
      dev_valid <= word_valid;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (word_valid) begin
      dev_data <= word;
      dev_pn   <= pn_dev_next(pn_seed);
    end
  end

endmodule

/* pn_seq_pkg.sv */
// PN sequence definitions
// polynomial select and next-word functions of the device and standard patterns
package pn_seq_pkg;

  import adc_types_pkg::*;

  // **************************************************
  // standard polynomials
  // **************************************************

  // PN9  x^9  + x^5  + 1
  // PN11 x^11 + x^9  + 1
  // PN15 x^15 + x^14 + 1
  // PN20 x^20 + x^3  + 1
  typedef enum logic [1:0] {
    PN9  = 2'd0,
    PN11 = 2'd1,
    PN15 = 2'd2,
    PN20 = 2'd3
  } prbs_poly_t;

  // **************************************************
  // device pattern
  // **************************************************

  // one step of the converter's own test pattern
  // new bit is xor of bits 15..4 and bits 2..1, shifted in at the bottom
  function automatic pn_dev_word_t pn_dev_next(input pn_dev_word_t din);
    logic fb;
    fb = (^din[15:4]) ^ (^din[2:1]);
    return {din[14:0], fb};
  endfunction

  // **************************************************
  // standard patterns
  // **************************************************

  // runs a fibonacci lfsr for a full checker word
  // the window holds the latest sequence bits, newest in bit 0, so
  // s[n] = s[n-len] ^ s[n-tap] reads bits len-1 and tap-1 of the window
  function automatic pn_word_t pn_lfsr_word(
    input pn_word_t din,
    input int       len,
    input int       tap
  );
    pn_word_t win;
    logic     nb;
    win = din;
    for (int i = 0; i < $bits(pn_word_t); i++) begin
      nb  = win[len-1] ^ win[tap-1];
      win = {win[$bits(pn_word_t)-2:0], nb};
    end
    // after a full word of shifts the window is the next word,
    // oldest bit in the msb
    return win;
  endfunction

  // next 24 bits of the chosen polynomial
  // only the low len bits of din act as seed
  function automatic pn_word_t pn_std_next(
    input prbs_poly_t poly,
    input pn_word_t   din
  );
    int len;
    int tap;
    case (poly)
      PN11: begin
        len = 11;
        tap = 9;
      end
      PN15: begin
        len = 15;
        tap = 14;
      end
      PN20: begin
        len = 20;
        tap = 3;
      end
      default: begin
        len = 9;
        tap = 5;
      end
    endcase
    return pn_lfsr_word(din, len, tap);
  endfunction

endpackage

/* adc_types_pkg.sv */
// ADC receive data path types
// one sample, the device pattern word and the checker word
`include "pn_defines.svh"

package adc_types_pkg;

  // one converter sample as delivered on the I or Q lane
  typedef logic [`PN_SAMPLE_W-1:0] adc_sample_t;

  // device pattern word, primary sample with the reversed secondary low nibble
  typedef logic [`PN_DEV_W-1:0] pn_dev_word_t;

  // checker word, also the width of the standard patterns
  typedef logic [`PN_STD_W-1:0] pn_word_t;

endpackage

/* pn_defines.svh */
// PN monitor build constants
// sample and word widths, sync thresholds and the stream select code
`ifndef PN_DEFINES_SVH
`define PN_DEFINES_SVH

// converter sample width
`define PN_SAMPLE_W 12

// device pattern word, one sample plus one nibble of the other channel
`define PN_DEV_W 16

// standard pattern word, two samples, also the checker width
`define PN_STD_W 24

// consecutive matches needed to leave out-of-sync
`define PN_LOCK_COUNT 16

// consecutive mismatches that drop back to out-of-sync
`define PN_LOSS_COUNT 16

// pnseq_sel code for the standard stream, all others pick the device stream
`define PN_SEL_STD 4'h9

`endif
